// File: Makefile
TOP = adma_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

// File: bench/adma_tb.sv
// ADMA testbench with RAM and FIFO models, six descriptor tests and a watchdog; top module adma_tb
`include "adma_defs.svh"

module adma_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [1:0] A_NOP  = 2'b00;   // attribute bits 5:4
   localparam logic [1:0] A_TRAN = 2'b10;
   localparam logic [1:0] A_LINK = 2'b11;
   localparam int TEST_WORST = 3000;   // cycles, covers the slowest test
   localparam int DRAIN_MAX = 200;
   localparam int WATCHDOG_CYCLES = 6 * TEST_WORST + 500;

   logic CLK, RESET;
   logic                reg_write = 1'b0;
   logic [1:0]          reg_addr = `ADMA_REG_STATUS;
   logic [`ADMA_DW-1:0] reg_wdata = '0;
   logic [`ADMA_DW-1:0] reg_rdata;
   logic                irq;
   logic [`ADMA_AW-1:0] ram_address;
   logic                ram_read, ram_write;
   logic [`ADMA_DW-1:0] data_to_ram;
   logic [`ADMA_DW-1:0] data_from_ram = '0;
   logic                fifo_full = 1'b0;
   logic                fifo_empty = 1'b1;
   logic                fifo_read, fifo_write;
   logic [`ADMA_DW-1:0] data_from_fifo = '0;
   logic [`ADMA_DW-1:0] data_to_fifo;

   logic [`ADMA_DW-1:0] mem [logic [`ADMA_AW-1:0]];   // sparse RAM
   logic [`ADMA_DW-1:0] fq[$];        // FIFO contents
   logic [`ADMA_DW-1:0] src_q[$];     // words the bench still has to push
   logic [`ADMA_DW-1:0] rx[$];        // words drained from the FIFO
   logic [`ADMA_AW-1:0] rd_log[$];    // every RAM read address
   integer seed = 66;
   int  errors = 0;
   int  checks = 0;
   int  tests = 0;
   int  hold = 0;
   bit  stress = 0;
   bit  feed = 0;      // bench fills the FIFO for the DUT instead of draining it
   int  ram_wr_cnt = 0;
   int  fifo_wr_cnt = 0;

   clock_gen clk_i (.CLK(CLK), .RESET(RESET));

   adma_top adma_top_i (.*);

   function automatic logic [`ADMA_DW-1:0] fill(input logic [`ADMA_AW-1:0] a);
      return a[31:0] ^ {a[47:32], a[63:48]} ^ 32'h5a5a_c3c3;
   endfunction

   function automatic logic [`ADMA_DW-1:0] ram_word(input logic [`ADMA_AW-1:0] a);
      return mem.exists(a) ? mem[a] : fill(a);
   endfunction

   // RAM model, one cycle read latency
   always @(posedge CLK) begin
      if (ram_read)
         data_from_ram <= ram_word(ram_address);
      if (ram_write)
         mem[ram_address] = data_to_ram;
      if (ram_read)
         rd_log.push_back(ram_address);
      if (!RESET && ram_write)
         ram_wr_cnt++;
      if (!RESET && fifo_write)
         fifo_wr_cnt++;
   end

   // FIFO model, depth 8, random fill and drain on the bench side
   always @(posedge CLK) begin
      if (fifo_write)
         fq.push_back(data_to_fifo);
      if (fifo_read && fq.size() > 0)
         data_from_fifo <= fq.pop_front();
      if (src_q.size() > 0 && fq.size() < 8 && ($random(seed) & 1))
         fq.push_back(src_q.pop_front());
      if (hold > 0)
         hold--;
      else if (stress && ($random(seed) & 3) == 0)
         hold = ($random(seed) & 15) + 4;   // keep the FIFO blocked a while
      else if (!feed && fq.size() > 0 && ($random(seed) & 1))
         rx.push_back(fq.pop_front());
      fifo_full  <= (fq.size() >= 8);
      fifo_empty <= (fq.size() == 0);
   end

   a_write_full: assert property (@(posedge CLK) disable iff (RESET)
      !(fifo_write && fifo_full))
      else begin
         $display("[FAIL] %0t fifo_write got 1 expected 0 while fifo_full", $time);
         errors++;
      end

   a_rd_wr: assert property (@(posedge CLK) disable iff (RESET) !(ram_read && ram_write))
      else begin
         $display("RAM read and write were issued in the same cycle at %0t", $time);
         errors++;
      end

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp)
      else begin
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic reg_wr(input logic [1:0] a, input logic [31:0] d);
      @(posedge CLK);
      reg_write <= 1'b1;
      reg_addr  <= a;
      reg_wdata <= d;
      @(posedge CLK);
      reg_write <= 1'b0;
      reg_addr  <= `ADMA_REG_STATUS;
   endtask

   task automatic put_desc(input logic [63:0] at, input logic v, input logic e, input logic i,
                           input logic [1:0] act, input logic [15:0] len,
                           input logic [63:0] target);
      mem[at]     = {len, 10'd0, act, 1'b0, i, e, v};
      mem[at + 4] = target[31:0];
      mem[at + 8] = target[63:32];
   endtask

   task automatic start_engine(input logic [63:0] at, input logic dir);
      reg_wr(`ADMA_REG_ADDR_LO, at[31:0]);
      reg_wr(`ADMA_REG_ADDR_HI, at[63:32]);
      reg_wr(`ADMA_REG_CTRL, (32'(dir) << `CTRL_DIR) | (32'd1 << `CTRL_GO));
   endtask

   // busy comes from the status register, sampled on the falling edge
   task automatic wait_idle();
      int n;
      n = 0;
      repeat (3) @(negedge CLK);
      while (reg_rdata[`STAT_BUSY] && n < TEST_WORST) begin
         @(negedge CLK);
         n++;
      end
      if (n >= TEST_WORST) begin
         $display("engine stayed busy for %0d cycles at %0t", n, $time);
         errors++;
      end
      n = 0;
      while (fq.size() > 0 && n < DRAIN_MAX) begin   // let the FIFO drain
         @(negedge CLK);
         n++;
      end
      if (n >= DRAIN_MAX) begin
         $display("FIFO still held %0d words after %0d cycles at %0t", fq.size(), n, $time);
         errors++;
      end
   endtask

   task automatic check_rx(input int first, input logic [63:0] base, input int n);
      check_val("rx count", rx.size(), first + n);
      for (int k = 0; k < n && first + k < rx.size(); k++)
         check_val("data_to_fifo", rx[first + k], fill(base + 4 * k));
   endtask

   task automatic end_test(input string name, input int err_before);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "failed");
      rx.delete();
      rd_log.delete();
   endtask

   initial begin
      int e0;
      int w0;
      int f0;
      logic [31:0] sent[$];
      logic [63:0] exp_rd[$];
      repeat (20) @(posedge CLK);

      // 1: single TRAN + END, RAM to FIFO
      e0 = errors;
      put_desc(64'h1000, 1, 1, 0, A_TRAN, 16'd32, 64'h0000_0001_0000_4000);
      start_engine(64'h1000, 1'b1);
      wait_idle();
      check_rx(0, 64'h0000_0001_0000_4000, 8);
      check_val("busy", reg_rdata[`STAT_BUSY], 0);
      end_test("ram_to_fifo", e0);

      // 2: FIFO to RAM
      e0 = errors;
      for (int k = 0; k < 12; k++)
         sent.push_back($random(seed));
      feed = 1;
      src_q = sent;
      put_desc(64'h1100, 1, 1, 0, A_TRAN, 16'd48, 64'h5000);
      start_engine(64'h1100, 1'b0);
      wait_idle();
      feed = 0;
      for (int k = 0; k < 12; k++)
         check_val("data_to_ram", ram_word(64'h5000 + 4 * k), sent[k]);
      end_test("fifo_to_ram", e0);

      // 3: NOP, LINK, then TRAN + END
      e0 = errors;
      put_desc(64'h2000, 1, 0, 0, A_NOP, 16'd0, 64'h0);
      put_desc(64'h200c, 1, 0, 0, A_LINK, 16'd0, 64'h2400);
      put_desc(64'h2400, 1, 1, 0, A_TRAN, 16'd16, 64'h6000);
      start_engine(64'h2000, 1'b1);
      wait_idle();
      for (int k = 0; k < 3; k++)
         exp_rd.push_back(64'h2000 + 4 * k);
      for (int k = 0; k < 3; k++)
         exp_rd.push_back(64'h200c + 4 * k);
      for (int k = 0; k < 3; k++)
         exp_rd.push_back(64'h2400 + 4 * k);
      for (int k = 0; k < 4; k++)
         exp_rd.push_back(64'h6000 + 4 * k);
      check_val("read count", rd_log.size(), exp_rd.size());
      for (int k = 0; k < exp_rd.size() && k < rd_log.size(); k++)
         check_val("ram_address", rd_log[k], exp_rd[k]);
      check_rx(0, 64'h6000, 4);
      end_test("chain", e0);

      // 4: back-pressure from a blocked FIFO
      e0 = errors;
      stress = 1;
      put_desc(64'h3000, 1, 1, 0, A_TRAN, 16'd160, 64'h7000);
      start_engine(64'h3000, 1'b1);
      wait_idle();
      stress = 0;
      check_rx(0, 64'h7000, 40);
      end_test("backpressure", e0);

      // 5: invalid descriptor
      e0 = errors;
      w0 = ram_wr_cnt;
      f0 = fifo_wr_cnt;
      put_desc(64'h3100, 0, 1, 0, A_TRAN, 16'd16, 64'h8000);
      start_engine(64'h3100, 1'b1);
      wait_idle();
      check_val("err", reg_rdata[`STAT_ERR], 1);
      check_val("ram_write count", ram_wr_cnt - w0, 0);
      check_val("fifo_write count", fifo_wr_cnt - f0, 0);
      reg_wr(`ADMA_REG_CTRL, 32'd1 << `CTRL_IRQ_CLR);
      end_test("invalid", e0);

      // 6: INT, then STOP during the block and cont
      e0 = errors;
      put_desc(64'h3200, 1, 0, 1, A_TRAN, 16'd64, 64'h9000);
      put_desc(64'h320c, 1, 1, 0, A_TRAN, 16'd16, 64'ha000);
      start_engine(64'h3200, 1'b1);
      repeat (12) @(posedge CLK);
      reg_wr(`ADMA_REG_CTRL, (32'd1 << `CTRL_DIR) | (32'd1 << `CTRL_STOP));
      wait_idle();
      check_rx(0, 64'h9000, 16);
      check_val("irq", irq, 1);
      reg_wr(`ADMA_REG_CTRL, (32'd1 << `CTRL_DIR) | (32'd1 << `CTRL_IRQ_CLR));
      @(negedge CLK);
      check_val("irq", irq, 0);
      reg_wr(`ADMA_REG_CTRL, (32'd1 << `CTRL_DIR) | (32'd1 << `CTRL_CONT));
      wait_idle();
      check_rx(16, 64'ha000, 4);
      end_test("int_stop_cont", e0);

      $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   // watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge CLK);
      $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end
endmodule

// File: bench/clock_gen.sv
// testbench clock and reset source; 8 ns CLK, RESET high for the first 16 cycles
module clock_gen (
   output logic CLK,
   output logic RESET
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   initial begin
      RESET = 1'b1;
      repeat (16) @(posedge CLK);
      RESET <= 1'b0;   // released on a rising edge
   end
endmodule

// File: files.f
+incdir+include
source/adma_pkg.sv
source/ram_port_if.sv
source/adma_regs.sv
source/desc_fetch.sv
source/data_mover.sv
source/adma_fsm.sv
source/adma_top.sv
bench/clock_gen.sv
bench/adma_tb.sv

// File: include/adma_defs.svh
// widths, register offsets and control bits for the ADMA; `include in RTL and bench files
`ifndef ADMA_DEFS_SVH
`define ADMA_DEFS_SVH

`define ADMA_AW          64   // RAM address width
`define ADMA_DW          32
`define ADMA_DESC_WORDS  3
`define ADMA_DESC_BYTES  12   // step to the next descriptor

// register offsets on reg_addr
`define ADMA_REG_ADDR_LO 2'd0
`define ADMA_REG_ADDR_HI 2'd1
`define ADMA_REG_CTRL    2'd2
`define ADMA_REG_STATUS  2'd3

// control register bits
`define CTRL_GO          0
`define CTRL_CONT        1    // resume at the saved descriptor address
`define CTRL_STOP        2
`define CTRL_DIR         3    // 1 = RAM to FIFO
`define CTRL_IRQ_CLR     4

// status register bits
`define STAT_BUSY        0
`define STAT_IRQ         1
`define STAT_ERR         2

`endif

// File: source/adma_fsm.sv
// ADMA descriptor-chain controller; walks the table, starts fetch and transfer, muxes the RAM port
`include "adma_defs.svh"

module adma_fsm (
   input  logic                 CLK,
   input  logic                 RESET,
   input  logic                 go,
   input  logic                 cont,
   input  logic                 stop_req,
   input  logic [`ADMA_AW-1:0]  start_addr,
   output logic                 busy,
   output logic                 int_pulse,
   output logic                 err_pulse,
   ram_port_if.owner            fetch_ram,
   ram_port_if.owner            move_ram,
   ram_port_if.requester        bus,
   output logic                 fetch_start,
   output logic [`ADMA_AW-1:0]  fetch_addr,
   input  logic                 fetch_done,
   input  adma_pkg::adma_desc_t desc,
   output logic                 move_start,
   input  logic                 move_done,
   output logic [`ADMA_AW-1:0]  base_addr,
   output logic [15:0]          length
);

   localparam logic [`ADMA_AW-1:0] DESC_STEP = `ADMA_DESC_BYTES;

   adma_pkg::adma_state_t state;
   adma_pkg::adma_state_t next_state;
   logic [`ADMA_AW-1:0]   desc_addr;    // current table pointer, also where cont resumes
   logic [`ADMA_AW-1:0]   next_addr;

   assign next_addr = (desc.act == adma_pkg::ACT_LINK) ? desc.address
                                                       : desc_addr + DESC_STEP;

   always_ff @(posedge CLK) begin
      if (RESET) begin
         state     <= adma_pkg::ST_STOP;
         desc_addr <= '0;
      end else begin
         state <= next_state;
         if (state == adma_pkg::ST_STOP && go)
            desc_addr <= start_addr;
         else if (state == adma_pkg::ST_CADR)
            desc_addr <= next_addr;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         adma_pkg::ST_STOP:
            if (go || cont)
               next_state = adma_pkg::ST_FDS_START;
         adma_pkg::ST_FDS_START: next_state = adma_pkg::ST_FDS;
         adma_pkg::ST_FDS:
            // an invalid descriptor ends the chain with an error
            if (fetch_done)
               next_state = desc.valid ? adma_pkg::ST_CADR : adma_pkg::ST_STOP;
         adma_pkg::ST_CADR:
            if (desc.act == adma_pkg::ACT_TRAN)
               next_state = adma_pkg::ST_TFR_START;
            else if (desc.end_flag)
               next_state = adma_pkg::ST_STOP;
            else
               next_state = adma_pkg::ST_FDS_START;   // nop, rsv, link
         adma_pkg::ST_TFR_START: next_state = adma_pkg::ST_TFR;
         adma_pkg::ST_TFR:
            if (move_done)
               next_state = (desc.end_flag || stop_req) ? adma_pkg::ST_STOP
                                                        : adma_pkg::ST_FDS_START;
         default: next_state = adma_pkg::ST_STOP;
      endcase
   end

   assign busy        = (state != adma_pkg::ST_STOP);
   assign fetch_start = (state == adma_pkg::ST_FDS_START);
   assign fetch_addr  = desc_addr;
   assign move_start  = (state == adma_pkg::ST_TFR_START);
   assign base_addr   = desc.address;
   assign length      = desc.length;
   assign int_pulse   = (state == adma_pkg::ST_CADR) && desc.int_en;
   assign err_pulse   = (state == adma_pkg::ST_FDS) && fetch_done && !desc.valid;

   // read data goes back to both engines
   assign fetch_ram.rdata = bus.rdata;
   assign move_ram.rdata  = bus.rdata;

   always_comb begin
      bus.addr  = desc_addr;
      bus.rd    = 1'b0;
      bus.wr    = 1'b0;
      bus.wdata = '0;
      case (state)
         adma_pkg::ST_FDS_START, adma_pkg::ST_FDS: begin
            bus.addr  = fetch_ram.addr;
            bus.rd    = fetch_ram.rd;
            bus.wr    = fetch_ram.wr;
            bus.wdata = fetch_ram.wdata;
         end
         adma_pkg::ST_TFR_START, adma_pkg::ST_TFR: begin
            bus.addr  = move_ram.addr;
            bus.rd    = move_ram.rd;
            bus.wr    = move_ram.wr;
            bus.wdata = move_ram.wdata;
         end
         default: bus.rd = 1'b0;   // stop and cadr keep the bus quiet
      endcase
   end

   // descriptor words only come back while the controller waits for them
   a_fetch_done_in_fds: assert property (@(posedge CLK) disable iff (RESET)
      fetch_done |-> state == adma_pkg::ST_FDS);

endmodule

// File: source/adma_pkg.sv
// types shared by the ADMA controller and its engines, used as adma_pkg::name
`include "adma_defs.svh"

package adma_pkg;

   // descriptor-chain controller states
   typedef enum logic [2:0] {
      ST_STOP,
      ST_FDS_START,   // kick off the descriptor fetch
      ST_FDS,
      ST_CADR,        // work out the next descriptor address
      ST_TFR_START,
      ST_TFR
   } adma_state_t;

   // attribute bits 5:4 of descriptor word 0
   typedef enum logic [1:0] {
      ACT_NOP  = 2'b00,
      ACT_RSV  = 2'b01,
      ACT_TRAN = 2'b10,
      ACT_LINK = 2'b11
   } adma_act_t;

   // same bit order as in RAM, word 2 on top
   typedef struct packed {
      logic [`ADMA_AW-1:0] address;
      logic [15:0]         length;    // bytes
      logic [9:0]          rsvd_hi;
      adma_act_t           act;
      logic                rsvd_lo;
      logic                int_en;
      logic                end_flag;
      logic                valid;
   } adma_desc_t;

endpackage

// File: source/adma_regs.sv
// ADMA register block; start address, direction, command pulses and irq/err status
`include "adma_defs.svh"

module adma_regs (
   input  logic                CLK,
   input  logic                RESET,
   input  logic                reg_write,
   input  logic [1:0]          reg_addr,
   input  logic [`ADMA_DW-1:0] reg_wdata,
   output logic [`ADMA_DW-1:0] reg_rdata,
   output logic [`ADMA_AW-1:0] start_addr,
   output logic                dir,
   output logic                go,
   output logic                cont,
   output logic                stop_req,
   input  logic                busy,
   input  logic                int_pulse,
   input  logic                err_pulse,
   output logic                irq
);

   logic err;
   logic ctrl_wr;

   assign ctrl_wr = reg_write && (reg_addr == `ADMA_REG_CTRL);

   always_ff @(posedge CLK) begin
      if (RESET) begin
         start_addr <= '0;
         dir        <= 1'b0;
         go         <= 1'b0;
         cont       <= 1'b0;
         stop_req   <= 1'b0;
         irq        <= 1'b0;
         err        <= 1'b0;
      end else begin
         go   <= ctrl_wr && reg_wdata[`CTRL_GO];     // single-cycle pulses
         cont <= ctrl_wr && reg_wdata[`CTRL_CONT];
         if (reg_write && reg_addr == `ADMA_REG_ADDR_LO)
            start_addr[`ADMA_DW-1:0] <= reg_wdata;
         if (reg_write && reg_addr == `ADMA_REG_ADDR_HI)
            start_addr[`ADMA_AW-1:`ADMA_DW] <= reg_wdata;
         if (ctrl_wr)
            dir <= reg_wdata[`CTRL_DIR];
         // stop stays pending until the engine is restarted
         if (ctrl_wr && reg_wdata[`CTRL_STOP])
            stop_req <= 1'b1;
         else if (ctrl_wr && (reg_wdata[`CTRL_GO] || reg_wdata[`CTRL_CONT]))
            stop_req <= 1'b0;
         if (int_pulse)
            irq <= 1'b1;
         else if (ctrl_wr && reg_wdata[`CTRL_IRQ_CLR])
            irq <= 1'b0;
         if (err_pulse)
            err <= 1'b1;
         else if (ctrl_wr && reg_wdata[`CTRL_IRQ_CLR])
            err <= 1'b0;
      end
   end

   always_comb begin
      reg_rdata = '0;
      case (reg_addr)
         `ADMA_REG_ADDR_LO: reg_rdata = start_addr[`ADMA_DW-1:0];
         `ADMA_REG_ADDR_HI: reg_rdata = start_addr[`ADMA_AW-1:`ADMA_DW];
         `ADMA_REG_CTRL: begin
            reg_rdata[`CTRL_DIR]  = dir;
            reg_rdata[`CTRL_STOP] = stop_req;
         end
         default: begin   // status
            reg_rdata[`STAT_BUSY] = busy;
            reg_rdata[`STAT_IRQ]  = irq;
            reg_rdata[`STAT_ERR]  = err;
         end
      endcase
   end

endmodule

// File: source/adma_top.sv
// ADMA top level; register, RAM and FIFO sides as plain ports, instantiated by the testbench
`include "adma_defs.svh"

module adma_top (
   input  logic                CLK,
   input  logic                RESET,
   input  logic                reg_write,
   input  logic [1:0]          reg_addr,
   input  logic [`ADMA_DW-1:0] reg_wdata,
   output logic [`ADMA_DW-1:0] reg_rdata,
   output logic                irq,
   output logic [`ADMA_AW-1:0] ram_address,
   output logic                ram_read,
   output logic                ram_write,
   output logic [`ADMA_DW-1:0] data_to_ram,
   input  logic [`ADMA_DW-1:0] data_from_ram,
   input  logic                fifo_full,
   input  logic                fifo_empty,
   output logic                fifo_read,
   output logic                fifo_write,
   input  logic [`ADMA_DW-1:0] data_from_fifo,
   output logic [`ADMA_DW-1:0] data_to_fifo
);

   logic [`ADMA_AW-1:0]  start_addr;
   logic [`ADMA_AW-1:0]  fetch_addr;
   logic [`ADMA_AW-1:0]  base_addr;
   logic [15:0]          length;
   logic                 dir;
   logic                 go;
   logic                 cont;
   logic                 stop_req;
   logic                 busy;
   logic                 int_pulse;
   logic                 err_pulse;
   logic                 fetch_start;
   logic                 fetch_done;
   logic                 move_start;
   logic                 move_done;
   adma_pkg::adma_desc_t desc;

   ram_port_if fetch_bus ();
   ram_port_if move_bus ();
   ram_port_if ram_bus ();    // after the mux, goes out to RAM

   assign ram_address   = ram_bus.addr;
   assign ram_read      = ram_bus.rd;
   assign ram_write     = ram_bus.wr;
   assign data_to_ram   = ram_bus.wdata;
   assign ram_bus.rdata = data_from_ram;

   adma_regs regs_i (
      .CLK(CLK), .RESET(RESET),
      .reg_write(reg_write), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
      .reg_rdata(reg_rdata), .start_addr(start_addr), .dir(dir),
      .go(go), .cont(cont), .stop_req(stop_req), .busy(busy),
      .int_pulse(int_pulse), .err_pulse(err_pulse), .irq(irq)
   );

   adma_fsm fsm_i (
      .CLK(CLK), .RESET(RESET),
      .go(go), .cont(cont), .stop_req(stop_req), .start_addr(start_addr),
      .busy(busy), .int_pulse(int_pulse), .err_pulse(err_pulse),
      .fetch_ram(fetch_bus.owner), .move_ram(move_bus.owner), .bus(ram_bus.requester),
      .fetch_start(fetch_start), .fetch_addr(fetch_addr), .fetch_done(fetch_done),
      .desc(desc), .move_start(move_start), .move_done(move_done),
      .base_addr(base_addr), .length(length)
   );

   desc_fetch fetch_i (
      .CLK(CLK), .RESET(RESET),
      .fetch_start(fetch_start), .fetch_addr(fetch_addr),
      .fetch_done(fetch_done), .desc(desc), .ram(fetch_bus.requester)
   );

   data_mover mover_i (
      .CLK(CLK), .RESET(RESET),
      .move_start(move_start), .dir(dir), .base_addr(base_addr), .length(length),
      .move_done(move_done), .ram(move_bus.requester),
      .fifo_full(fifo_full), .fifo_empty(fifo_empty),
      .fifo_read(fifo_read), .fifo_write(fifo_write),
      .data_from_fifo(data_from_fifo), .data_to_fifo(data_to_fifo)
   );

endmodule

// File: source/data_mover.sv
// moves one TRAN block between RAM and the data FIFO, started by move_start, ends on move_done
`include "adma_defs.svh"

module data_mover (
   input  logic                CLK,
   input  logic                RESET,
   input  logic                move_start,
   input  logic                dir,          // 1 = RAM to FIFO
   input  logic [`ADMA_AW-1:0] base_addr,
   input  logic [15:0]         length,       // bytes
   output logic                move_done,
   ram_port_if.requester       ram,
   input  logic                fifo_full,
   input  logic                fifo_empty,
   output logic                fifo_read,
   output logic                fifo_write,
   input  logic [`ADMA_DW-1:0] data_from_fifo,
   output logic [`ADMA_DW-1:0] data_to_fifo
);

   localparam logic [`ADMA_AW-1:0] WORD_STEP = 4;

   logic                active;
   logic                dir_q;
   logic [13:0]         total_q;    // words in this block
   logic [13:0]         issued;
   logic [13:0]         done_cnt;
   logic                pend_q;     // request went out last cycle
   logic                skid_v;
   logic [`ADMA_DW-1:0] skid_q;
   logic [`ADMA_AW-1:0] addr_q;
   logic                more;

   assign more = active && (issued != total_q);

   // RAM to FIFO, hold off while the skid is in use
   assign ram.rd       = more && dir_q && !fifo_full && !skid_v;
   assign fifo_write   = dir_q && !fifo_full && (skid_v || pend_q);
   assign data_to_fifo = skid_v ? skid_q : ram.rdata;

   // FIFO to RAM, the popped word is written when it shows up
   assign fifo_read = more && !dir_q && !fifo_empty;
   assign ram.wr    = pend_q && !dir_q;
   assign ram.wdata = data_from_fifo;
   assign ram.addr  = addr_q;

   assign move_done = active && (done_cnt == total_q);

   always_ff @(posedge CLK) begin
      if (RESET) begin
         active   <= 1'b0;
         dir_q    <= 1'b0;
         total_q  <= '0;
         issued   <= '0;
         done_cnt <= '0;
         pend_q   <= 1'b0;
         skid_v   <= 1'b0;
         addr_q   <= '0;
      end else if (move_start) begin
         active   <= 1'b1;
         dir_q    <= dir;
         total_q  <= length[15:2];   // whole words only
         issued   <= '0;
         done_cnt <= '0;
         pend_q   <= 1'b0;
         skid_v   <= 1'b0;
         addr_q   <= base_addr;
      end else begin
         pend_q <= ram.rd || fifo_read;
         if (ram.rd || fifo_read)
            issued <= issued + 14'd1;
         if (ram.rd || ram.wr)
            addr_q <= addr_q + WORD_STEP;
         if (fifo_write || ram.wr)
            done_cnt <= done_cnt + 14'd1;
         if (dir_q && pend_q && fifo_full)
            skid_v <= 1'b1;          // FIFO filled up under the read
         else if (fifo_write)
            skid_v <= 1'b0;
         if (move_done)
            active <= 1'b0;
      end
   end

   always_ff @(posedge CLK) begin
      if (dir_q && pend_q && fifo_full)
         skid_q <= ram.rdata;
   end

   // a word only completes after it was requested
   a_done_after_issue: assert property (@(posedge CLK) disable iff (RESET)
      active |-> done_cnt <= issued);

   // a read never lands while the skid still holds a word
   a_skid_no_overrun: assert property (@(posedge CLK) disable iff (RESET)
      skid_v && dir_q |-> !pend_q);

endmodule

// File: source/desc_fetch.sv
// fetches one three-word descriptor from RAM, started by fetch_start, done on fetch_done
`include "adma_defs.svh"

module desc_fetch (
   input  logic                 CLK,
   input  logic                 RESET,
   input  logic                 fetch_start,
   input  logic [`ADMA_AW-1:0]  fetch_addr,
   output logic                 fetch_done,
   output adma_pkg::adma_desc_t desc,
   ram_port_if.requester        ram
);

   localparam logic [2:0] LAST_WORD = 3'(`ADMA_DESC_WORDS);
   localparam logic [2:0] DONE_PH   = 3'(`ADMA_DESC_WORDS + 1);

   logic [2:0]          phase;    // 0 idle, 1..3 word lands, 4 done
   logic [`ADMA_AW-1:0] base_q;
   logic [`ADMA_DW-1:0] words [`ADMA_DESC_WORDS];

   always_ff @(posedge CLK) begin
      if (RESET)
         phase <= 3'd0;
      else if (fetch_start)
         phase <= 3'd1;   // word 0 was requested this cycle
      else if (phase == DONE_PH)
         phase <= 3'd0;
      else if (phase != 3'd0)
         phase <= phase + 3'd1;
   end

   always_ff @(posedge CLK) begin
      if (fetch_start)
         base_q <= fetch_addr;
      // rdata holds the word asked for in the previous cycle
      if (phase != 3'd0 && phase <= LAST_WORD)
         words[2'(phase - 3'd1)] <= ram.rdata;
   end

   // reads on three back-to-back cycles, the first one straight off fetch_start
   assign ram.rd    = fetch_start || (phase != 3'd0 && phase < LAST_WORD);
   assign ram.addr  = fetch_start ? fetch_addr
                                  : base_q + {{(`ADMA_AW-5){1'b0}}, phase, 2'b00};
   assign ram.wr    = 1'b0;       // read only
   assign ram.wdata = '0;

   assign fetch_done = (phase == DONE_PH);
   assign desc       = adma_pkg::adma_desc_t'({words[2], words[1], words[0]});

   // the controller waits for fetch_done before it asks again
   a_no_refetch: assert property (@(posedge CLK) disable iff (RESET)
      fetch_start |-> phase == 3'd0);

endmodule

// File: source/ram_port_if.sv
// RAM request bundle between the ADMA engines and the port mux in the controller
`include "adma_defs.svh"

interface ram_port_if;
   logic [`ADMA_AW-1:0] addr;
   logic                rd;      // data back one cycle later
   logic                wr;
   logic [`ADMA_DW-1:0] wdata;
   logic [`ADMA_DW-1:0] rdata;

   // engine side
   modport requester (
      output addr, rd, wr, wdata,
      input  rdata
   );

   // mux side
   modport owner (
      input  addr, rd, wr, wdata,
      output rdata
   );
endinterface
